// ==== pipeline_pkg.sv ====
package pipeline_pkg;

    localparam int reg_width = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_num = 32;
    localparam int csr_addr_width = 14;
    localparam int excp_num_width = 16;
    localparam int excp_idx_width = 4;
    localparam int esubcode_width = 9;
    localparam int vppn_width = 19;

    localparam logic [reg_width-1:0] eentry_addr = 32'h1c00_8000;

    localparam logic [esubcode_width-1:0] esubcode_adef = 9'd0;
    localparam logic [esubcode_width-1:0] esubcode_adem = 9'd1;

    // excp_num bit positions, lower bit wins
    localparam int excp_bit_int = 0;
    localparam int excp_bit_adef = 1;
    localparam int excp_bit_tlbr_f = 2;
    localparam int excp_bit_pif = 3;
    localparam int excp_bit_ppi_f = 4;
    localparam int excp_bit_sys = 5;
    localparam int excp_bit_brk = 6;
    localparam int excp_bit_ine = 7;
    localparam int excp_bit_ipe = 8;
    localparam int excp_bit_ale = 9;
    localparam int excp_bit_adem = 10;
    localparam int excp_bit_tlbr_d = 11;
    localparam int excp_bit_pme = 12;
    localparam int excp_bit_ppi_d = 13;
    localparam int excp_bit_pis = 14;
    localparam int excp_bit_pil = 15;

    typedef enum logic [7:0] {
        op_other   = 8'h00,
        op_ertn    = 8'h4a,
        op_syscall = 8'h4b,
        op_break   = 8'h4c
    } alu_op_e;

    typedef enum logic [5:0] {
        ecode_int  = 6'h00,
        ecode_pil  = 6'h01,
        ecode_pis  = 6'h02,
        ecode_pif  = 6'h03,
        ecode_pme  = 6'h04,
        ecode_ppi  = 6'h07,
        ecode_ade  = 6'h08,
        ecode_ale  = 6'h09,
        ecode_sys  = 6'h0b,
        ecode_brk  = 6'h0c,
        ecode_ine  = 6'h0d,
        ecode_ipe  = 6'h0e,
        ecode_tlbr = 6'h3f
    } ecode_e;

    typedef struct packed {
        logic                      we;
        logic [reg_addr_width-1:0] waddr;
        logic [reg_width-1:0]      wdata;
        logic [reg_width-1:0]      pc;
    } reg_write_t;

    typedef struct packed {
        logic                      we;
        logic [csr_addr_width-1:0] waddr;
        logic [reg_width-1:0]      wdata;
    } csr_write_t;

    // reg_w.wdata carries the faulting address on a memory exception
    typedef struct packed {
        logic                      valid;
        alu_op_e                   aluop;
        logic [reg_width-1:0]      instr;
        logic                      excp;
        logic [excp_num_width-1:0] excp_num;
        reg_write_t                reg_w;
        csr_write_t                csr_w;
    } wb_lane_t;

    typedef struct packed {
        ecode_e                    ecode;
        logic [esubcode_width-1:0] esubcode;
        logic                      va_error;
        logic [reg_width-1:0]      bad_va;
        logic                      tlbrefill;
        logic                      tlb;
        logic [vppn_width-1:0]     vppn;
    } excp_info_t;

    // {ex_mem, dispatch_ex, id_dispatch, fetch_id, unused}
    typedef logic [4:0] stall_t;

    localparam stall_t stall_none = 5'b00000;
    localparam stall_t stall_from_ex_mem = 5'b11110;
    localparam stall_t stall_from_dispatch = 5'b11100;

endpackage

// ==== mem_wb.sv ====
`timescale 1ns/100ps

module mem_wb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  pipeline_pkg::wb_lane_t lane0_i,
    input  pipeline_pkg::wb_lane_t lane1_i,
    output pipeline_pkg::wb_lane_t wb0_o,
    output pipeline_pkg::wb_lane_t wb1_o
);

    import pipeline_pkg::*;

    logic kill;

    // a flush drops whatever the memory stage offers this edge
    assign kill = rst | flush_i;

    always_ff @(posedge clk) begin
        wb0_o <= lane0_i;
        wb1_o <= lane1_i;
        if (kill) begin
            wb0_o.valid <= 1'b0;
            wb0_o.excp  <= 1'b0;
            wb1_o.valid <= 1'b0;
            wb1_o.excp  <= 1'b0;
        end
    end

endmodule

// ==== ctrl.sv ====
`timescale 1ns/100ps

module ctrl (
    input  logic                      rst,
    input  pipeline_pkg::wb_lane_t    wb0_i,
    input  pipeline_pkg::wb_lane_t    wb1_i,
    input  logic [1:0]                ex_branch_flag_i,
    input  logic [1:0]                ex_stallreq_i,
    input  logic [1:0]                mem_stallreq_i,
    input  logic                      dispatch_stallreq_i,
    output logic                      excp_flush_o,
    output logic                      ertn_flush_o,
    output logic                      flush_o,
    output logic                      ex_mem_flush_o,
    output pipeline_pkg::stall_t      stall_o,
    output pipeline_pkg::reg_write_t  reg_w0_o,
    output pipeline_pkg::reg_write_t  reg_w1_o,
    output pipeline_pkg::csr_write_t  csr_w0_o,
    output pipeline_pkg::csr_write_t  csr_w1_o,
    output pipeline_pkg::excp_info_t  excp_info_o,
    output logic [31:0]               era_o,
    output logic [31:0]               excp_instr_o
);

    import pipeline_pkg::*;

    logic excp0, excp1;
    logic lane0_blocks;
    logic commit0, commit1;
    logic [excp_num_width-1:0] sel_num;
    logic [reg_width-1:0] sel_pc;
    logic [reg_width-1:0] sel_err_va;
    logic [excp_idx_width-1:0] excp_idx;
    logic excp_hit;

    assign excp0 = wb0_i.valid & wb0_i.excp;
    assign excp1 = wb1_i.valid & wb1_i.excp;

    // lane 0 ending the block stops lane 1 from committing
    assign lane0_blocks = excp0 | (wb0_i.valid & (wb0_i.aluop == op_ertn |
                                                  wb0_i.aluop == op_syscall |
                                                  wb0_i.aluop == op_break));

    assign commit0 = wb0_i.valid & ~wb0_i.excp;
    assign commit1 = wb1_i.valid & ~wb1_i.excp & ~lane0_blocks;

    always_comb begin
        reg_w0_o = wb0_i.reg_w;
        reg_w0_o.we = wb0_i.reg_w.we & commit0;
        reg_w1_o = wb1_i.reg_w;
        reg_w1_o.we = wb1_i.reg_w.we & commit1;
        csr_w0_o = wb0_i.csr_w;
        csr_w0_o.we = wb0_i.csr_w.we & commit0;
        csr_w1_o = wb1_i.csr_w;
        csr_w1_o.we = wb1_i.csr_w.we & commit1;
    end

    assign excp_flush_o = excp0 | excp1;
    assign ertn_flush_o = (wb0_i.valid & wb0_i.aluop == op_ertn) |
                          (wb1_i.valid & wb1_i.aluop == op_ertn);
    assign flush_o = excp_flush_o | ertn_flush_o;
    assign ex_mem_flush_o = ex_branch_flag_i[0];

    always_comb begin
        if (rst) begin
            stall_o = stall_none;
        end else if (|ex_stallreq_i || |mem_stallreq_i) begin
            stall_o = stall_from_ex_mem;
        end else if (dispatch_stallreq_i) begin
            stall_o = stall_from_dispatch;
        end else begin
            stall_o = stall_none;
        end
    end

    // lane 0 is older, so its exception wins
    always_comb begin
        if (excp0) begin
            sel_num = wb0_i.excp_num;
            sel_pc = wb0_i.reg_w.pc;
            sel_err_va = wb0_i.reg_w.wdata;
            excp_instr_o = wb0_i.instr;
        end else if (excp1) begin
            sel_num = wb1_i.excp_num;
            sel_pc = wb1_i.reg_w.pc;
            sel_err_va = wb1_i.reg_w.wdata;
            excp_instr_o = wb1_i.instr;
        end else begin
            sel_num = '0;
            sel_pc = '0;
            sel_err_va = '0;
            excp_instr_o = '0;
        end
    end

    assign era_o = sel_pc;

    // lowest set bit
    always_comb begin
        excp_idx = '0;
        excp_hit = 1'b0;
        for (int i = excp_num_width - 1; i >= 0; i--) begin
            if (sel_num[i]) begin
                excp_idx = excp_idx_width'(i);
                excp_hit = 1'b1;
            end
        end
    end

    always_comb begin
        excp_info_o = '0;
        if (excp_hit) begin
            case (excp_idx)
                excp_bit_int: excp_info_o.ecode = ecode_int;
                excp_bit_adef: begin
                    excp_info_o.ecode = ecode_ade;
                    excp_info_o.esubcode = esubcode_adef;
                    excp_info_o.va_error = 1'b1;
                    excp_info_o.bad_va = sel_pc;
                end
                excp_bit_tlbr_f, excp_bit_pif, excp_bit_ppi_f: begin
                    excp_info_o.ecode = (excp_idx == excp_bit_tlbr_f) ? ecode_tlbr :
                                        (excp_idx == excp_bit_pif) ? ecode_pif : ecode_ppi;
                    excp_info_o.va_error = 1'b1;
                    excp_info_o.bad_va = sel_pc;
                    excp_info_o.tlb = 1'b1;
                    excp_info_o.tlbrefill = (excp_idx == excp_bit_tlbr_f);
                end
                excp_bit_sys: excp_info_o.ecode = ecode_sys;
                excp_bit_brk: excp_info_o.ecode = ecode_brk;
                excp_bit_ine: excp_info_o.ecode = ecode_ine;
                excp_bit_ipe: excp_info_o.ecode = ecode_ipe;
                excp_bit_ale, excp_bit_adem: begin
                    excp_info_o.ecode = (excp_idx == excp_bit_ale) ? ecode_ale : ecode_ade;
                    excp_info_o.esubcode = (excp_idx == excp_bit_adem) ? esubcode_adem : '0;
                    excp_info_o.va_error = 1'b1;
                    excp_info_o.bad_va = sel_err_va;
                end
                default: begin
                    // tlb faults on data access
                    excp_info_o.ecode = (excp_idx == excp_bit_tlbr_d) ? ecode_tlbr :
                                        (excp_idx == excp_bit_pme) ? ecode_pme :
                                        (excp_idx == excp_bit_ppi_d) ? ecode_ppi :
                                        (excp_idx == excp_bit_pis) ? ecode_pis : ecode_pil;
                    excp_info_o.va_error = 1'b1;
                    excp_info_o.bad_va = sel_err_va;
                    excp_info_o.tlb = 1'b1;
                    excp_info_o.tlbrefill = (excp_idx == excp_bit_tlbr_d);
                end
            endcase
        end
        excp_info_o.vppn = excp_info_o.tlb ? excp_info_o.bad_va[reg_width-1 -: vppn_width] : '0;
    end

endmodule

// ==== csr_excp.sv ====
`timescale 1ns/100ps

module csr_excp (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     excp_flush_i,
    input  logic                     ertn_flush_i,
    input  pipeline_pkg::excp_info_t excp_info_i,
    input  logic [31:0]              era_i,
    output logic [31:0]              era_o,
    output logic [31:0]              badv_o,
    output logic [31:0]              redirect_pc_o,
    output pipeline_pkg::ecode_e     ecode_o,
    output logic [8:0]               esubcode_o,
    output logic [18:0]              vppn_o,
    output logic                     tlbrfill_o
);

    import pipeline_pkg::*;

    logic [reg_width-1:0] era_q;
    logic [reg_width-1:0] badv_q;
    ecode_e ecode_q;
    logic [esubcode_width-1:0] esubcode_q;
    logic [vppn_width-1:0] vppn_q;
    logic tlbrfill_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            era_q <= '0;
            badv_q <= '0;
            ecode_q <= ecode_int;
            esubcode_q <= '0;
            vppn_q <= '0;
            tlbrfill_q <= 1'b0;
        end else if (excp_flush_i) begin
            era_q <= era_i;
            ecode_q <= excp_info_i.ecode;
            esubcode_q <= excp_info_i.esubcode;
            if (excp_info_i.va_error) begin
                badv_q <= excp_info_i.bad_va;
            end
            if (excp_info_i.tlb) begin
                vppn_q <= excp_info_i.vppn;
            end
            if (excp_info_i.tlbrefill) begin
                tlbrfill_q <= 1'b1;
            end
        end else if (ertn_flush_i) begin
            // leaving the refill handler
            tlbrfill_q <= 1'b0;
        end
    end

    always_comb begin
        if (excp_flush_i) begin
            redirect_pc_o = eentry_addr;
        end else if (ertn_flush_i) begin
            redirect_pc_o = era_q;
        end else begin
            redirect_pc_o = '0;
        end
    end

    assign era_o = era_q;
    assign badv_o = badv_q;
    assign ecode_o = ecode_q;
    assign esubcode_o = esubcode_q;
    assign vppn_o = vppn_q;
    assign tlbrfill_o = tlbrfill_q;

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  pipeline_pkg::reg_write_t w0_i,
    input  pipeline_pkg::reg_write_t w1_i,
    input  logic [4:0]               raddr_i,
    output logic [31:0]              rdata_o
);

    import pipeline_pkg::*;

    logic [reg_width-1:0] regs [reg_num];

    // port 1 is written last, so it wins on a matching address
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w0_i.we && w0_i.waddr != '0) begin
                regs[w0_i.waddr] <= w0_i.wdata;
            end
            if (w1_i.we && w1_i.waddr != '0) begin
                regs[w1_i.waddr] <= w1_i.wdata;
            end
        end
    end

    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// ==== commit_top.sv ====
`timescale 1ns/100ps

module commit_top (
    input  logic                     clk,
    input  logic                     rst,
    input  pipeline_pkg::wb_lane_t   lane0_i,
    input  pipeline_pkg::wb_lane_t   lane1_i,
    input  logic [1:0]               ex_stallreq_i,
    input  logic [1:0]               mem_stallreq_i,
    input  logic                     dispatch_stallreq_i,
    input  logic [1:0]               ex_branch_flag_i,
    input  logic [4:0]               raddr_i,
    output logic [31:0]              rdata_o,
    output pipeline_pkg::stall_t     stall_o,
    output logic                     excp_flush_o,
    output logic                     ertn_flush_o,
    output logic                     flush_o,
    output logic                     ex_mem_flush_o,
    output pipeline_pkg::csr_write_t csr_w0_o,
    output pipeline_pkg::csr_write_t csr_w1_o,
    output logic [31:0]              excp_instr_o,
    output logic [31:0]              redirect_pc_o,
    output logic [31:0]              era_o,
    output logic [31:0]              badv_o,
    output pipeline_pkg::ecode_e     ecode_o,
    output logic [8:0]               esubcode_o,
    output logic [18:0]              vppn_o,
    output logic                     tlbrfill_o
);

    import pipeline_pkg::*;

    wb_lane_t wb0, wb1;
    reg_write_t reg_w0, reg_w1;
    excp_info_t excp_info;
    logic [reg_width-1:0] excp_era;

    mem_wb u_mem_wb (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_o),
        .lane0_i (lane0_i),
        .lane1_i (lane1_i),
        .wb0_o   (wb0),
        .wb1_o   (wb1)
    );

    ctrl u_ctrl (
        .rst                 (rst),
        .wb0_i               (wb0),
        .wb1_i               (wb1),
        .ex_branch_flag_i    (ex_branch_flag_i),
        .ex_stallreq_i       (ex_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .excp_flush_o        (excp_flush_o),
        .ertn_flush_o        (ertn_flush_o),
        .flush_o             (flush_o),
        .ex_mem_flush_o      (ex_mem_flush_o),
        .stall_o             (stall_o),
        .reg_w0_o            (reg_w0),
        .reg_w1_o            (reg_w1),
        .csr_w0_o            (csr_w0_o),
        .csr_w1_o            (csr_w1_o),
        .excp_info_o         (excp_info),
        .era_o               (excp_era),
        .excp_instr_o        (excp_instr_o)
    );

    csr_excp u_csr_excp (
        .clk           (clk),
        .rst           (rst),
        .excp_flush_i  (excp_flush_o),
        .ertn_flush_i  (ertn_flush_o),
        .excp_info_i   (excp_info),
        .era_i         (excp_era),
        .era_o         (era_o),
        .badv_o        (badv_o),
        .redirect_pc_o (redirect_pc_o),
        .ecode_o       (ecode_o),
        .esubcode_o    (esubcode_o),
        .vppn_o        (vppn_o),
        .tlbrfill_o    (tlbrfill_o)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .w0_i    (reg_w0),
        .w1_i    (reg_w1),
        .raddr_i (raddr_i),
        .rdata_o (rdata_o)
    );

endmodule

// ==== tb_commit_top.sv ====
`timescale 1ns/100ps

module tb_commit_top;

    import pipeline_pkg::*;

    localparam int max_tests = 16;
    localparam int wait_limit = 64;
    localparam logic [31:0] pc_base = 32'h1c00_0100;

    typedef struct packed {
        wb_lane_t    lane0;
        wb_lane_t    lane1;
        logic [4:0]  reqs;
        stall_t      exp_stall;
        logic        exp_excp;
        logic        exp_ertn;
        ecode_e      exp_ecode;
        logic [8:0]  exp_esubcode;
        logic [31:0] exp_badv;
        logic [31:0] exp_era;
        logic [31:0] exp_redirect;
        logic        exp_tlbrfill;
    } test_t;

    logic clk;
    logic rst;
    wb_lane_t lane0_i, lane1_i;
    logic [1:0] ex_stallreq_i, mem_stallreq_i, ex_branch_flag_i;
    logic dispatch_stallreq_i;
    logic [4:0] raddr_i;
    logic [31:0] rdata_o, excp_instr_o, redirect_pc_o, era_o, badv_o;
    stall_t stall_o;
    logic excp_flush_o, ertn_flush_o, flush_o, ex_mem_flush_o, tlbrfill_o;
    csr_write_t csr_w0_o, csr_w1_o;
    ecode_e ecode_o;
    logic [8:0] esubcode_o;
    logic [18:0] vppn_o;

    test_t tests [max_tests];
    string test_names [max_tests];
    logic [31:0] model_regs [32];
    int n_tests = 0;
    int errors = 0;
    int passed = 0;
    int failed = 0;
    int rise_cnt = 0;
    int seed;

    commit_top DUT (
        .clk                 (clk),
        .rst                 (rst),
        .lane0_i             (lane0_i),
        .lane1_i             (lane1_i),
        .ex_stallreq_i       (ex_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .ex_branch_flag_i    (ex_branch_flag_i),
        .raddr_i             (raddr_i),
        .rdata_o             (rdata_o),
        .stall_o             (stall_o),
        .excp_flush_o        (excp_flush_o),
        .ertn_flush_o        (ertn_flush_o),
        .flush_o             (flush_o),
        .ex_mem_flush_o      (ex_mem_flush_o),
        .csr_w0_o            (csr_w0_o),
        .csr_w1_o            (csr_w1_o),
        .excp_instr_o        (excp_instr_o),
        .redirect_pc_o       (redirect_pc_o),
        .era_o               (era_o),
        .badv_o              (badv_o),
        .ecode_o             (ecode_o),
        .esubcode_o          (esubcode_o),
        .vppn_o              (vppn_o),
        .tlbrfill_o          (tlbrfill_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        rise_cnt <= rise_cnt + 1;
    end

    // returns on the falling edge after n rising edges
    task automatic wait_cycles(input int n);
        int target;
        int tries;
        target = rise_cnt + n;
        tries = 0;
        while (rise_cnt < target && tries < wait_limit) begin
            @(negedge clk);
            tries++;
        end
        if (rise_cnt < target) begin
            $display("timeout: clock did not advance %0d cycles", n);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ecode(input string name, input ecode_e got, input ecode_e exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stall(input string name, input stall_t got, input stall_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic wb_lane_t make_lane(input alu_op_e op, input logic [4:0] waddr,
                                           input logic [31:0] wdata, input logic [31:0] pc,
                                           input logic [15:0] excp_num);
        wb_lane_t l;
        l = '0;
        l.valid = 1'b1;
        l.aluop = op;
        l.instr = rand_word();
        l.excp = |excp_num;
        l.excp_num = excp_num;
        l.reg_w.we = 1'b1;
        l.reg_w.waddr = waddr;
        l.reg_w.wdata = wdata;
        l.reg_w.pc = pc;
        l.csr_w.we = 1'b1;
        l.csr_w.waddr = 14'h6;
        l.csr_w.wdata = rand_word();
        return l;
    endfunction

    // commit rules, lane 1 written last so it wins on the same register
    task automatic model_commit(input wb_lane_t l0, input wb_lane_t l1,
                                output logic c0, output logic c1);
        logic blocks;
        blocks = l0.valid && (l0.excp || l0.aluop == op_ertn || l0.aluop == op_syscall ||
                              l0.aluop == op_break);
        c0 = l0.valid && !l0.excp;
        c1 = l1.valid && !l1.excp && !blocks;
        if (c0 && l0.reg_w.we && l0.reg_w.waddr != 5'd0) begin
            model_regs[l0.reg_w.waddr] = l0.reg_w.wdata;
        end
        if (c1 && l1.reg_w.we && l1.reg_w.waddr != 5'd0) begin
            model_regs[l1.reg_w.waddr] = l1.reg_w.wdata;
        end
    endtask

    function automatic stall_t expected_stall(input logic [1:0] ex, input logic [1:0] mem,
                                              input logic disp);
        if (ex != 2'b00 || mem != 2'b00) begin
            return 5'b11110;
        end
        if (disp) begin
            return 5'b11100;
        end
        return 5'b00000;
    endfunction

    task automatic add_test(input string name, input wb_lane_t l0, input wb_lane_t l1,
                            input logic [4:0] reqs, input stall_t stall, input logic excp,
                            input logic ertn, input ecode_e ecode, input logic [8:0] esubcode,
                            input logic [31:0] badv, input logic [31:0] era,
                            input logic [31:0] redirect, input logic tlbrfill);
        test_names[n_tests] = name;
        tests[n_tests] = '{l0, l1, reqs, stall, excp, ertn, ecode, esubcode, badv, era,
                           redirect, tlbrfill};
        n_tests++;
    endtask

    task automatic build_table();
        logic [31:0] fault;
        logic [15:0] both;
        add_test("separate registers",
                 make_lane(op_other, 5'd1, rand_word(), pc_base, '0),
                 make_lane(op_other, 5'd2, rand_word(), pc_base + 4, '0),
                 5'b00000, 5'b00000, 1'b0, 1'b0, ecode_int, 9'd0, '0, '0, '0, 1'b0);
        add_test("same register",
                 make_lane(op_other, 5'd3, rand_word(), pc_base + 8, '0),
                 make_lane(op_other, 5'd3, rand_word(), pc_base + 12, '0),
                 5'b00001, 5'b11100, 1'b0, 1'b0, ecode_int, 9'd0, '0, '0, '0, 1'b0);
        add_test("register zero",
                 make_lane(op_other, 5'd0, rand_word(), pc_base + 16, '0),
                 make_lane(op_other, 5'd4, rand_word(), pc_base + 20, '0),
                 5'b01000, 5'b11110, 1'b0, 1'b0, ecode_int, 9'd0, '0, '0, '0, 1'b0);
        add_test("syscall blocks lane 1",
                 make_lane(op_syscall, 5'd5, rand_word(), pc_base + 24, '0),
                 make_lane(op_other, 5'd6, rand_word(), pc_base + 28, '0),
                 5'b00100, 5'b11110, 1'b0, 1'b0, ecode_int, 9'd0, '0, '0, '0, 1'b0);
        add_test("break blocks lane 1",
                 make_lane(op_break, 5'd6, rand_word(), pc_base + 32, '0),
                 make_lane(op_other, 5'd7, rand_word(), pc_base + 36, '0),
                 5'b00000, 5'b00000, 1'b0, 1'b0, ecode_int, 9'd0, '0, '0, '0, 1'b0);
        // no exception yet, so ERA still holds its reset value
        add_test("ertn blocks lane 1",
                 make_lane(op_ertn, 5'd9, rand_word(), pc_base + 40, '0),
                 make_lane(op_other, 5'd10, rand_word(), pc_base + 44, '0),
                 5'b00000, 5'b00000, 1'b0, 1'b1, ecode_int, 9'd0, '0, '0, 32'h0, 1'b0);
        fault = rand_word();
        add_test("ale on lane 1",
                 make_lane(op_other, 5'd7, rand_word(), pc_base + 48, '0),
                 make_lane(op_other, 5'd8, fault, pc_base + 52, 16'(1 << excp_bit_ale)),
                 5'b00000, 5'b00000, 1'b1, 1'b0, ecode_ale, 9'd0, fault, pc_base + 52,
                 eentry_addr, 1'b0);
        fault = rand_word();
        add_test("adem on lane 1",
                 make_lane(op_other, 5'd15, rand_word(), pc_base + 72, '0),
                 make_lane(op_other, 5'd16, fault, pc_base + 76, 16'(1 << excp_bit_adem)),
                 5'b00000, 5'b00000, 1'b1, 1'b0, ecode_ade, esubcode_adem, fault,
                 pc_base + 76, eentry_addr, 1'b0);
        fault = rand_word();
        both = 16'(1 << excp_bit_tlbr_d) | 16'(1 << excp_bit_ppi_d) | 16'(1 << excp_bit_pil);
        add_test("both lanes excp, tlbr",
                 make_lane(op_other, 5'd11, fault, pc_base + 56, both),
                 make_lane(op_other, 5'd12, rand_word(), pc_base + 60, 16'(1 << excp_bit_ine)),
                 5'b00000, 5'b00000, 1'b1, 1'b0, ecode_tlbr, 9'd0, fault, pc_base + 56,
                 eentry_addr, 1'b1);
        add_test("ertn returns to era",
                 make_lane(op_ertn, 5'd13, rand_word(), pc_base + 64, '0),
                 make_lane(op_other, 5'd14, rand_word(), pc_base + 68, '0),
                 5'b00000, 5'b00000, 1'b0, 1'b1, ecode_int, 9'd0, '0, '0, pc_base + 56,
                 1'b0);
    endtask

    task automatic read_reg(input logic [4:0] addr);
        raddr_i = addr;
        #0.5;
        check_word($sformatf("r%0d", addr), rdata_o, model_regs[addr]);
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: FAILED with %0d mismatches", name, errors - errs_before);
        end
    endtask

    task automatic run_test(input int idx);
        test_t t;
        logic c0, c1;
        int errs_before;
        t = tests[idx];
        errs_before = errors;
        lane0_i = t.lane0;
        lane1_i = t.lane1;
        {ex_stallreq_i, mem_stallreq_i, dispatch_stallreq_i} = t.reqs;
        #1;
        check_stall("stall_o", stall_o, t.exp_stall);
        model_commit(t.lane0, t.lane1, c0, c1);
        wait_cycles(1);
        lane0_i = '0;
        lane1_i = '0;
        {ex_stallreq_i, mem_stallreq_i, dispatch_stallreq_i} = '0;
        // lanes now sit in writeback
        check_word("excp_flush_o", 32'(excp_flush_o), 32'(t.exp_excp));
        check_word("ertn_flush_o", 32'(ertn_flush_o), 32'(t.exp_ertn));
        check_word("flush_o", 32'(flush_o), 32'(t.exp_excp | t.exp_ertn));
        check_word("redirect_pc_o", redirect_pc_o, t.exp_redirect);
        check_word("csr_w0_o.we", 32'(csr_w0_o.we), 32'(c0 & t.lane0.csr_w.we));
        check_word("csr_w1_o.we", 32'(csr_w1_o.we), 32'(c1 & t.lane1.csr_w.we));
        check_word("csr_w0_o.wdata", csr_w0_o.wdata, t.lane0.csr_w.wdata);
        check_word("csr_w1_o.wdata", csr_w1_o.wdata, t.lane1.csr_w.wdata);
        // the older faulting lane supplies the instruction word
        if (t.exp_excp) begin
            check_word("excp_instr_o", excp_instr_o,
                       t.lane0.excp ? t.lane0.instr : t.lane1.instr);
        end
        wait_cycles(1);
        if (t.exp_excp) begin
            check_ecode("ecode_o", ecode_o, t.exp_ecode);
            check_word("esubcode_o", 32'(esubcode_o), 32'(t.exp_esubcode));
            check_word("badv_o", badv_o, t.exp_badv);
            check_word("era_o", era_o, t.exp_era);
        end
        check_word("tlbrfill_o", 32'(tlbrfill_o), 32'(t.exp_tlbrfill));
        if (t.exp_tlbrfill) begin
            check_word("vppn_o", 32'(vppn_o), 32'(t.exp_badv[31:13]));
        end
        read_reg(t.lane0.reg_w.waddr);
        read_reg(t.lane1.reg_w.waddr);
        read_reg(5'd0);
        report(test_names[idx], errs_before);
        wait_cycles(1);
    endtask

    task automatic sweep_stall();
        int errs_before;
        logic [4:0] combo;
        errs_before = errors;
        for (int i = 0; i < 32; i++) begin
            combo = 5'(i);
            {ex_stallreq_i, mem_stallreq_i, dispatch_stallreq_i} = combo;
            ex_branch_flag_i = combo[1:0];
            #1;
            check_stall("stall_o", stall_o, expected_stall(combo[4:3], combo[2:1], combo[0]));
            check_word("ex_mem_flush_o", 32'(ex_mem_flush_o), 32'(combo[0]));
            wait_cycles(1);
        end
        {ex_stallreq_i, mem_stallreq_i, dispatch_stallreq_i} = '0;
        ex_branch_flag_i = 2'b00;
        report("stall merge sweep", errs_before);
    endtask

    initial begin
        int errs_before;
        seed = 32'h7c2f;
        rst = 1'b1;
        lane0_i = '0;
        lane1_i = '0;
        ex_stallreq_i = 2'b01;
        mem_stallreq_i = 2'b00;
        dispatch_stallreq_i = 1'b1;
        ex_branch_flag_i = 2'b00;
        raddr_i = 5'd0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        build_table();
        wait_cycles(16);
        // stall stays low in reset even with requests pending
        errs_before = errors;
        check_stall("stall_o", stall_o, 5'b00000);
        check_word("flush_o", 32'(flush_o), 32'h0);
        check_word("era_o", era_o, 32'h0);
        check_word("badv_o", badv_o, 32'h0);
        rst = 1'b0;
        ex_stallreq_i = 2'b00;
        dispatch_stallreq_i = 1'b0;
        report("reset state", errs_before);
        wait_cycles(1);
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        sweep_stall();
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
pipeline_pkg.sv
mem_wb.sv
ctrl.sv
csr_excp.sv
regfile.sv
commit_top.sv
tb_commit_top.sv

// ==== Bender.yml ====
package:
  name: commit_ctrl

sources:
  - pipeline_pkg.sv
  - mem_wb.sv
  - ctrl.sv
  - csr_excp.sv
  - regfile.sv
  - commit_top.sv
  - target: test
    files:
      - tb_commit_top.sv
